//--- Makefile
# Verilator build for the active-mode command flow

VERILATOR ?= verilator
TOP       ?= tb_flow_active
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Testbench passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- list.f
+incdir+logic
+incdir+verif
logic/flow_pkg.sv
logic/cmd_decoder.sv
logic/dat_reader.sv
logic/xfer_sequencer.sv
logic/flow_active.sv
verif/tb_flow_active.sv

//--- logic/cmd_decoder.sv
/* Command decoder: takes a descriptor from the command queue and
   presents it as an immediate-transfer record */
`timescale 1ns/100ps
`include "flow_consts.svh"

module cmd_decoder
  import flow_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      cmd_take_i,
  input  logic      cmd_valid_i,
  input  cmd_desc_t cmd_data_i,
  output logic      cmd_ready_o,
  output imm_xfer_t xfer_o
);

  cmd_desc_t desc_q;
  logic      def_byte;

  // Ready only while the sequencer is waiting for a command
  assign cmd_ready_o = cmd_take_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      desc_q <= '0;
    end else if (cmd_valid_i && cmd_ready_o) begin
      desc_q <= cmd_data_i;
    end
  end

  // DTT 5..7 means a defining byte sits in byte1
  assign def_byte = (desc_q.dtt >= 3'(`FLOW_DEF_BYTE_DTT));

  always_comb begin
    xfer_o           = '0;
    xfer_o.tid       = desc_q.tid;
    xfer_o.dev_index = desc_q.dev_index;
    xfer_o.toc       = desc_q.toc;
    // Only immediate writes can run here
    // Device type is checked by the sequencer
    xfer_o.exec      = (desc_q.attr == CMD_IMMEDIATE) && !desc_q.rnw;
    if (def_byte) begin
      xfer_o.count      = desc_q.dtt - 3'(`FLOW_DEF_BYTE_DTT);
      // Defining byte is dropped, payload starts at byte2
      xfer_o.payload[0] = desc_q.byte2;
      xfer_o.payload[1] = desc_q.byte3;
      xfer_o.payload[2] = desc_q.byte4;
      xfer_o.payload[3] = '0;
    end else begin
      xfer_o.count      = desc_q.dtt;
      xfer_o.payload[0] = desc_q.byte1;
      xfer_o.payload[1] = desc_q.byte2;
      xfer_o.payload[2] = desc_q.byte3;
      xfer_o.payload[3] = desc_q.byte4;
    end
  end

endmodule

//--- logic/dat_reader.sv
/* DAT reader: read strobe generation and capture of the device entry */
`timescale 1ns/100ps
`include "flow_consts.svh"

module dat_reader
  import flow_pkg::*;
(
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       fetch_i,
  input  logic [`FLOW_DAT_IDX_W-1:0] dev_index_i,
  output logic                       dat_read_o,
  output logic [`FLOW_DAT_IDX_W-1:0] dat_index_o,
  input  dat_entry_t                 dat_rdata_i,
  output dat_info_t                  info_o,
  output logic                       done_o
);

  logic      read_q;
  logic      rdata_vld_q;
  logic      done_q;
  dat_info_t info_q;

  // Strobe, then read data one cycle later, then done after capture
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      read_q      <= 1'b0;
      rdata_vld_q <= 1'b0;
      done_q      <= 1'b0;
    end else begin
      read_q      <= fetch_i;
      rdata_vld_q <= read_q;
      done_q      <= rdata_vld_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rdata_vld_q) begin
      info_q.static_addr <= dat_rdata_i.static_addr;
      info_q.legacy_i2c  <= dat_rdata_i.legacy_i2c;
    end
  end

  assign dat_read_o  = read_q;
  // Decoder record is already stable when the strobe is high
  assign dat_index_o = dev_index_i;
  assign info_o      = info_q;
  assign done_o      = done_q;

endmodule

//--- logic/flow_active.sv
/* Active-mode flow top: decoder, DAT reader and sequencer on the
   command, DAT, format and response queue ports */
`timescale 1ns/100ps
`include "flow_consts.svh"

module flow_active
  import flow_pkg::*;
(
  input  logic                       clk_i,
  input  logic                       rst_ni,
  // Command queue
  input  logic                       cmd_valid_i,
  output logic                       cmd_ready_o,
  input  cmd_desc_t                  cmd_data_i,
  // Device address table
  output logic                       dat_read_o,
  output logic [`FLOW_DAT_IDX_W-1:0] dat_index_o,
  input  dat_entry_t                 dat_rdata_i,
  // I2C format queue
  output logic                       fmt_valid_o,
  input  logic                       fmt_ready_i,
  output fmt_word_t                  fmt_word_o,
  // Response queue
  output logic                       resp_valid_o,
  input  logic                       resp_ready_i,
  output resp_desc_t                 resp_data_o,
  input  logic                       flow_en_i,
  output logic                       idle_o
);

  imm_xfer_t xfer;
  dat_info_t dat_info;
  logic      cmd_take;
  logic      dat_fetch;
  logic      dat_done;

  cmd_decoder u_cmd_decoder (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .cmd_take_i  (cmd_take),
    .cmd_valid_i (cmd_valid_i),
    .cmd_data_i  (cmd_data_i),
    .cmd_ready_o (cmd_ready_o),
    .xfer_o      (xfer)
  );

  dat_reader u_dat_reader (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .fetch_i     (dat_fetch),
    .dev_index_i (xfer.dev_index),
    .dat_read_o  (dat_read_o),
    .dat_index_o (dat_index_o),
    .dat_rdata_i (dat_rdata_i),
    .info_o      (dat_info),
    .done_o      (dat_done)
  );

  xfer_sequencer u_xfer_sequencer (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .flow_en_i    (flow_en_i),
    .cmd_valid_i  (cmd_valid_i),
    .xfer_i       (xfer),
    .info_i       (dat_info),
    .dat_done_i   (dat_done),
    .cmd_take_o   (cmd_take),
    .dat_fetch_o  (dat_fetch),
    .fmt_valid_o  (fmt_valid_o),
    .fmt_ready_i  (fmt_ready_i),
    .fmt_word_o   (fmt_word_o),
    .resp_valid_o (resp_valid_o),
    .resp_ready_i (resp_ready_i),
    .resp_data_o  (resp_data_o),
    .idle_o       (idle_o)
  );

endmodule

//--- logic/flow_consts.svh
/* Width, DAT depth and immediate-transfer limit constants
   for the active-mode command flow */
`ifndef FLOW_CONSTS_SVH
`define FLOW_CONSTS_SVH

// Queue descriptor widths
`define FLOW_CMD_W 64
`define FLOW_RESP_W 32

// Device address table, 32 entries
`define FLOW_DAT_W 64
`define FLOW_DAT_IDX_W 5

// Format queue byte
`define FLOW_BYTE_W 8

// Immediate payload limit
`define FLOW_MAX_IMM 4

// DTT codes from here on carry a defining byte
`define FLOW_DEF_BYTE_DTT 5

`endif

//--- logic/flow_pkg.sv
/* Descriptor, DAT entry and response types, plus the records passed
   between decoder, DAT reader and sequencer */
`include "flow_consts.svh"

package flow_pkg;

  typedef enum logic [2:0] {
    CMD_REGULAR     = 3'd0,
    CMD_IMMEDIATE   = 3'd1,
    CMD_ADDR_ASSIGN = 3'd2,
    CMD_COMBO       = 3'd3,
    CMD_INTERNAL    = 3'd7
  } cmd_attr_e;

  // Command queue entry, immediate-transfer layout
  typedef struct packed {
    logic [`FLOW_BYTE_W-1:0]    byte4;
    logic [`FLOW_BYTE_W-1:0]    byte3;
    logic [`FLOW_BYTE_W-1:0]    byte2;
    logic [`FLOW_BYTE_W-1:0]    byte1;
    logic                       toc;
    logic                       rsvd30;
    logic                       rnw;
    logic [2:0]                 rsvd28_26;
    logic [2:0]                 dtt;
    logic [1:0]                 rsvd22_21;
    logic [`FLOW_DAT_IDX_W-1:0] dev_index;
    logic [8:0]                 rsvd15_7;
    logic [3:0]                 tid;
    cmd_attr_e                  attr;
  } cmd_desc_t;

  typedef struct packed {
    logic [31:0] rsvd63_32;
    logic        legacy_i2c;
    logic [23:0] rsvd30_7;
    logic [6:0]  static_addr;
  } dat_entry_t;

  typedef enum logic [3:0] {
    RESP_SUCCESS       = 4'h0,
    RESP_NOT_SUPPORTED = 4'hB
  } resp_err_e;

  typedef struct packed {
    resp_err_e   err_status;
    logic [3:0]  tid;
    logic [7:0]  rsvd23_16;
    logic [15:0] data_length;
  } resp_desc_t;

  // Decoded immediate transfer
  // payload[0] goes out first
  typedef struct packed {
    logic [3:0]                                   tid;
    logic [`FLOW_DAT_IDX_W-1:0]                   dev_index;
    logic                                         toc;
    logic                                         exec;
    logic [2:0]                                   count;
    logic [`FLOW_MAX_IMM-1:0][`FLOW_BYTE_W-1:0]   payload;
  } imm_xfer_t;

  typedef struct packed {
    logic       legacy_i2c;
    logic [6:0] static_addr;
  } dat_info_t;

  typedef struct packed {
    logic                    start_before;
    logic                    stop_after;
    logic [`FLOW_BYTE_W-1:0] data;
  } fmt_word_t;

endpackage

//--- logic/xfer_sequencer.sv
/* Flow FSM: command fetch, DAT lookup, format byte streaming and
   response write */
`timescale 1ns/100ps

module xfer_sequencer
  import flow_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       flow_en_i,
  input  logic       cmd_valid_i,
  input  imm_xfer_t  xfer_i,
  input  dat_info_t  info_i,
  input  logic       dat_done_i,
  output logic       cmd_take_o,
  output logic       dat_fetch_o,
  output logic       fmt_valid_o,
  input  logic       fmt_ready_i,
  output fmt_word_t  fmt_word_o,
  output logic       resp_valid_o,
  input  logic       resp_ready_i,
  output resp_desc_t resp_data_o,
  output logic       idle_o
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_WAIT_CMD,
    ST_FETCH_DAT,
    ST_WRITE_IMM,
    ST_WRITE_RESP
  } state_e;

  state_e     state_q;
  state_e     state_d;
  logic [2:0] byte_cnt_q;
  logic [1:0] pay_idx;
  logic       exec_ok;
  logic       dat_ready;
  logic       streaming;
  logic       responding;
  logic       fmt_fire;
  logic       resp_fire;
  logic       last_word;

  // Immediate write to a legacy I2C device is the only executable case
  assign exec_ok   = xfer_i.exec && info_i.legacy_i2c;
  assign dat_ready = (state_q == ST_FETCH_DAT) && dat_done_i;

  // Valid goes up in the same cycle the DAT entry arrives
  assign streaming  = (state_q == ST_WRITE_IMM) || (dat_ready && exec_ok);
  assign responding = (state_q == ST_WRITE_RESP) || (dat_ready && !exec_ok);
  assign fmt_fire   = streaming && fmt_ready_i;
  assign resp_fire  = responding && resp_ready_i;

  // Word 0 is the address, words 1..count the payload
  assign last_word = (byte_cnt_q == xfer_i.count);
  assign pay_idx   = 2'(byte_cnt_q - 3'd1);

  assign cmd_take_o  = (state_q == ST_WAIT_CMD);
  assign dat_fetch_o = cmd_take_o && cmd_valid_i;
  assign idle_o      = (state_q == ST_IDLE);

  always_comb begin
    fmt_word_o              = '0;
    fmt_word_o.start_before = (byte_cnt_q == 3'd0);
    fmt_word_o.stop_after   = last_word && xfer_i.toc;
    if (byte_cnt_q == 3'd0) begin
      fmt_word_o.data = {info_i.static_addr, 1'b0};
    end else begin
      fmt_word_o.data = xfer_i.payload[pay_idx];
    end
  end
  assign fmt_valid_o = streaming;

  // Record and DAT info are held until the next command
  always_comb begin
    resp_data_o            = '0;
    resp_data_o.err_status = exec_ok ? RESP_SUCCESS : RESP_NOT_SUPPORTED;
    resp_data_o.tid        = xfer_i.tid;
  end
  assign resp_valid_o = responding;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (flow_en_i) state_d = ST_WAIT_CMD;
      end
      ST_WAIT_CMD: begin
        if (cmd_valid_i) state_d = ST_FETCH_DAT;
      end
      ST_FETCH_DAT: begin
        if (dat_done_i) begin
          if (!exec_ok) begin
            state_d = resp_fire ? ST_IDLE : ST_WRITE_RESP;
          end else if (fmt_fire && last_word) begin
            state_d = ST_WRITE_RESP;
          end else begin
            state_d = ST_WRITE_IMM;
          end
        end
      end
      ST_WRITE_IMM: begin
        if (fmt_fire && last_word) state_d = ST_WRITE_RESP;
      end
      ST_WRITE_RESP: begin
        if (resp_ready_i) state_d = ST_IDLE;
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= ST_IDLE;
      byte_cnt_q <= '0;
    end else begin
      state_q <= state_d;
      // Counter only moves on an accepted word
      if (dat_fetch_o) begin
        byte_cnt_q <= '0;
      end else if (fmt_fire) begin
        byte_cnt_q <= byte_cnt_q + 3'd1;
      end
    end
  end

endmodule

//--- verif/tb_flow_vectors.svh
/* Command table: descriptors, DAT entries, expected format bytes and
   expected responses */

  // Columns: attr, tid, dev index, dtt, rnw, toc, {byte4..byte1}, static addr, legacy
  //          then format word count, expected bytes {last..first}, response status
  task automatic load_vectors();
    // Immediate writes, DTT 0 to 4
    add_row(CMD_IMMEDIATE, 1, 1, 0, 0, 1, 32'h44332211, 7'h50, 1,
            1, 40'hA0, RESP_SUCCESS);
    add_row(CMD_IMMEDIATE, 2, 2, 1, 0, 1, 32'h99887711, 7'h51, 1,
            2, 40'h11A2, RESP_SUCCESS);
    add_row(CMD_IMMEDIATE, 3, 3, 2, 0, 0, 32'hDDCCBBAA, 7'h12, 1,
            3, 40'hBBAA24, RESP_SUCCESS);
    add_row(CMD_IMMEDIATE, 4, 4, 3, 0, 1, 32'h04030201, 7'h7F, 1,
            4, 40'h030201FE, RESP_SUCCESS);
    add_row(CMD_IMMEDIATE, 5, 5, 4, 0, 1, 32'h88776655, 7'h08, 1,
            5, 40'h8877665510, RESP_SUCCESS);
    // Defining byte in byte1 is never sent
    add_row(CMD_IMMEDIATE, 6, 6, 5, 0, 1, 32'h443322D5, 7'h33, 1,
            1, 40'h66, RESP_SUCCESS);
    add_row(CMD_IMMEDIATE, 7, 7, 6, 0, 1, 32'hC3C2C1D6, 7'h20, 1,
            2, 40'hC140, RESP_SUCCESS);
    add_row(CMD_IMMEDIATE, 8, 8, 7, 0, 0, 32'h3A2A1AD7, 7'h01, 1,
            3, 40'h2A1A02, RESP_SUCCESS);
    // Commands this flow cannot execute
    add_row(CMD_REGULAR, 9, 9, 2, 0, 1, 32'h00002211, 7'h15, 1,
            0, 40'h0, RESP_NOT_SUPPORTED);
    add_row(CMD_IMMEDIATE, 10, 10, 1, 1, 1, 32'h00000033, 7'h16, 1,
            0, 40'h0, RESP_NOT_SUPPORTED);
    add_row(CMD_IMMEDIATE, 11, 11, 2, 0, 1, 32'h00005544, 7'h17, 0,
            0, 40'h0, RESP_NOT_SUPPORTED);
    add_row(CMD_COMBO, 12, 12, 0, 0, 1, 32'h00000000, 7'h18, 1,
            0, 40'h0, RESP_NOT_SUPPORTED);
    add_row(CMD_INTERNAL, 13, 13, 0, 0, 1, 32'h00000000, 7'h19, 1,
            0, 40'h0, RESP_NOT_SUPPORTED);
    // Full payload with stop left open, then one more unsupported
    add_row(CMD_IMMEDIATE, 15, 31, 4, 0, 0, 32'hF0E1D2C3, 7'h6A, 1,
            5, 40'hF0E1D2C3D4, RESP_SUCCESS);
    add_row(CMD_ADDR_ASSIGN, 0, 0, 0, 0, 1, 32'h00000000, 7'h1A, 1,
            0, 40'h0, RESP_NOT_SUPPORTED);
  endtask

//--- verif/tb_flow_active.sv
/* Testbench for the active-mode flow: clock, reset, DAT model, random
   queue back-pressure, command table loop and output checks */
`timescale 1ns/100ps
`include "flow_consts.svh"

module tb_flow_active
  import flow_pkg::*;
();

  logic                       clk_i;
  logic                       rst_ni;
  logic                       cmd_valid_i;
  logic                       cmd_ready_o;
  cmd_desc_t                  cmd_data_i;
  logic                       dat_read_o;
  logic [`FLOW_DAT_IDX_W-1:0] dat_index_o;
  dat_entry_t                 dat_rdata_i;
  logic                       fmt_valid_o;
  logic                       fmt_ready_i;
  fmt_word_t                  fmt_word_o;
  logic                       resp_valid_o;
  logic                       resp_ready_i;
  resp_desc_t                 resp_data_o;
  logic                       flow_en_i;
  logic                       idle_o;

  // Table columns, one entry per command
  cmd_desc_t   row_cmd[$];
  logic [3:0]  row_tid[$];
  bit          row_toc[$];
  int          row_words[$];
  logic [39:0] row_bytes[$];
  resp_err_e   row_status[$];

  dat_entry_t                 dat_mem [1 << `FLOW_DAT_IDX_W];
  logic [`FLOW_DAT_IDX_W-1:0] dat_addr;
  bit                         dat_req;

  integer     seed;
  int         errors;
  int         taken_cnt;
  int         resp_cnt;
  int         fmt_cnt;
  int         cur;
  int         word_idx;
  bit         vectors_ready;
  bit         fmt_hold;
  bit         resp_hold;
  bit         idle_due;
  fmt_word_t  fmt_held;
  resp_desc_t resp_held;

  flow_active u_flow_active (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .cmd_valid_i  (cmd_valid_i),
    .cmd_ready_o  (cmd_ready_o),
    .cmd_data_i   (cmd_data_i),
    .dat_read_o   (dat_read_o),
    .dat_index_o  (dat_index_o),
    .dat_rdata_i  (dat_rdata_i),
    .fmt_valid_o  (fmt_valid_o),
    .fmt_ready_i  (fmt_ready_i),
    .fmt_word_o   (fmt_word_o),
    .resp_valid_o (resp_valid_o),
    .resp_ready_i (resp_ready_i),
    .resp_data_o  (resp_data_o),
    .flow_en_i    (flow_en_i),
    .idle_o       (idle_o)
  );

  `include "tb_flow_vectors.svh"

  task automatic add_row(input cmd_attr_e attr, input int tid, input int idx, input int dtt,
                         input int rnw, input int toc, input logic [31:0] payload,
                         input logic [6:0] addr, input int legacy, input int words,
                         input logic [39:0] exp_bytes, input resp_err_e status);
    cmd_desc_t  d;
    dat_entry_t e;
    d           = '0;
    d.attr      = attr;
    d.tid       = 4'(tid);
    d.dev_index = `FLOW_DAT_IDX_W'(idx);
    d.dtt       = 3'(dtt);
    d.rnw       = (rnw != 0);
    d.toc       = (toc != 0);
    {d.byte4, d.byte3, d.byte2, d.byte1} = payload;
    // Reserved bits set so the DUT has to ignore them
    e             = '1;
    e.static_addr = addr;
    e.legacy_i2c  = (legacy != 0);
    dat_mem[idx]  = e;
    row_cmd.push_back(d);
    row_tid.push_back(4'(tid));
    row_toc.push_back(toc != 0);
    row_words.push_back(words);
    row_bytes.push_back(exp_bytes);
    row_status.push_back(status);
  endtask

  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  task automatic expect_quiet_outputs();
    assert (idle_o && !cmd_ready_o && !dat_read_o && !fmt_valid_o && !resp_valid_o) else begin
      errors++;
      $display("Outputs not in their idle state at %0t", $time);
    end
  endtask

  task automatic report_counts();
    $display("Summary: %0d errors, %0d commands taken, %0d format words, %0d responses",
             errors, taken_cnt, fmt_cnt, resp_cnt);
  endtask

  task automatic check_format_word();
    fmt_word_t exp_word;
    bit        expected;
    if (fmt_hold) begin
      assert (fmt_valid_o && fmt_word_o == fmt_held) else begin
        errors++;
        $display("Format word changed or dropped at %0t before it was accepted", $time);
      end
    end
    fmt_hold = 1'b0;
    if (fmt_valid_o && fmt_ready_i) begin
      expected = (taken_cnt > resp_cnt) && (word_idx < row_words[cur]);
      assert (expected) else begin
        errors++;
        $display("Unexpected format word at %0t for command %0d", $time, cur);
      end
      if (expected) begin
        exp_word              = '0;
        exp_word.start_before = (word_idx == 0);
        exp_word.stop_after   = row_toc[cur] && (word_idx == row_words[cur] - 1);
        exp_word.data         = row_bytes[cur][8*word_idx +: 8];
        assert (fmt_word_o == exp_word) else begin
          errors++;
          $display("error %0t: command %0d word %0d is %h, expected %h",
                   $time, cur, word_idx, fmt_word_o, exp_word);
        end
      end
      word_idx++;
      fmt_cnt++;
    end else if (fmt_valid_o) begin
      fmt_hold = 1'b1;
      fmt_held = fmt_word_o;
    end
  endtask

  task automatic score_response();
    resp_desc_t exp_resp;
    bit         expected;
    if (resp_hold) begin
      assert (resp_valid_o && resp_data_o == resp_held) else begin
        errors++;
        $display("Response changed or dropped at %0t before it was accepted", $time);
      end
    end
    resp_hold = 1'b0;
    if (resp_valid_o && resp_ready_i) begin
      expected = (taken_cnt > resp_cnt);
      assert (expected) else begin
        errors++;
        $display("Response at %0t with no command outstanding", $time);
      end
      if (expected) begin
        assert (word_idx == row_words[cur]) else begin
          errors++;
          $display("Response for command %0d at %0t after %0d of %0d format words",
                   cur, $time, word_idx, row_words[cur]);
        end
        exp_resp            = '0;
        exp_resp.err_status = row_status[cur];
        exp_resp.tid        = row_tid[cur];
        assert (resp_data_o == exp_resp) else begin
          errors++;
          $display("error %0t: response for command %0d is %h, expected %h",
                   $time, cur, resp_data_o, exp_resp);
        end
      end
      resp_cnt++;
      idle_due = 1'b1;
    end else if (resp_valid_o) begin
      resp_hold = 1'b1;
      resp_held = resp_data_o;
    end
  endtask

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // Ready about three cycles in four on both queues
  always @(posedge clk_i) begin
    #1;
    fmt_ready_i  = ($random(seed) & 3) != 0;
    resp_ready_i = ($random(seed) & 3) != 0;
  end

  // DAT answers in the cycle after the read strobe
  always @(posedge clk_i) begin
    if (dat_req) begin
      #1;
      dat_rdata_i = dat_mem[dat_addr];
      dat_req     = 1'b0;
    end
  end

  // Outputs sampled mid-cycle
  // Transfers happen at the next rising edge
  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (idle_due) begin
        assert (idle_o) else begin
          errors++;
          $display("Sequencer not idle at %0t after a response", $time);
        end
        idle_due = 1'b0;
      end
      if (cmd_valid_i && cmd_ready_o) begin
        assert (resp_cnt == taken_cnt) else begin
          errors++;
          $display("Command taken at %0t before the previous response", $time);
        end
        cur      = taken_cnt;
        word_idx = 0;
        taken_cnt++;
      end
      if (dat_read_o) begin
        assert (dat_index_o == row_cmd[cur].dev_index) else begin
          errors++;
          $display("error %0t: DAT index %0d, expected %0d",
                   $time, dat_index_o, row_cmd[cur].dev_index);
        end
        dat_req  = 1'b1;
        dat_addr = dat_index_o;
      end
      check_format_word();
      score_response();
    end
  end

  initial begin : watchdog
    int limit;
    int cycles;
    wait (vectors_ready);
    limit  = row_cmd.size() * 40 + 100;
    cycles = 0;
    while (cycles < limit) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("Run stopped by timeout after %0d cycles with %0d of %0d responses",
             cycles, resp_cnt, row_cmd.size());
    report_counts();
    $display("Testbench failed");
    $finish;
  end

  initial begin
    seed         = 32'h9890;
    rst_ni       = 1'b0;
    cmd_valid_i  = 1'b0;
    cmd_data_i   = '0;
    dat_rdata_i  = '0;
    fmt_ready_i  = 1'b0;
    resp_ready_i = 1'b0;
    flow_en_i    = 1'b0;
    for (int i = 0; i < (1 << `FLOW_DAT_IDX_W); i++) begin
      dat_mem[i] = {32'hDA7A_0000 | 32'(i), 1'b0, 24'h0, 7'(i)};
    end
    load_vectors();
    vectors_ready = 1'b1;

    @(posedge clk_i);
    @(negedge clk_i);
    expect_quiet_outputs();
    @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    @(negedge clk_i);
    expect_quiet_outputs();

    // Command offered while the flow is disabled
    next_cycle();
    cmd_valid_i = 1'b1;
    cmd_data_i  = row_cmd[0];
    repeat (5) begin
      @(negedge clk_i);
      assert (idle_o && !cmd_ready_o) else begin
        errors++;
        $display("Command accepted at %0t while the flow is disabled", $time);
      end
    end
    next_cycle();
    flow_en_i = 1'b1;

    for (int r = 0; r < row_cmd.size(); r++) begin
      cmd_valid_i = 1'b1;
      cmd_data_i  = row_cmd[r];
      @(negedge clk_i);
      while (!cmd_ready_o) @(negedge clk_i);
      next_cycle();
    end
    cmd_valid_i = 1'b0;
    cmd_data_i  = '0;

    while (resp_cnt < row_cmd.size()) @(posedge clk_i);
    repeat (4) @(posedge clk_i);
    assert (taken_cnt == row_cmd.size()) else begin
      errors++;
      $display("Only %0d of %0d commands were taken", taken_cnt, row_cmd.size());
    end

    report_counts();
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule
